// ==== compile.f ====
+incdir+verilog
verilog/l2_pkg.sv
verilog/l2_if.sv
verilog/l2_line_store.sv
verilog/l2_lru.sv
verilog/l2_controller.sv
verilog/l2_cache_top.sv
tb/l2_cache_assert.sv
tb/l2_cache_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing --assert -Wall
TOP       := l2_cache_tb
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^STATUS: PASS" $(LOG) || (echo "Simulation did not pass"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/l2_cache_tb.sv ====
// L2 cache testbench
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2_cache_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_ACC      = 400;
    localparam int ACC_CYCLES   = 40;           // Worst access is two full line transfers
    localparam int DIRECTED_ACC = 6;

    logic          CLK;
    logic          nRST;
    logic          proc_ren;
    logic          proc_wen;
    l2_pkg::word_t proc_addr;
    l2_pkg::word_t proc_wdata;
    l2_pkg::word_t proc_rdata;
    logic          proc_busy;
    logic          mem_ren;
    logic          mem_wen;
    l2_pkg::word_t mem_addr;
    l2_pkg::word_t mem_wdata;
    l2_pkg::word_t mem_rdata = '0;
    logic          mem_busy = 1'b1;

    int            seed = 62;
    int            error_count = 0;
    int unsigned   wait_left = 0;               // Stall cycles left for the memory

    // Reference model
    l2_pkg::word_t            exp_words [l2_pkg::word_t];
    l2_pkg::word_t            mem_words [l2_pkg::word_t];
    logic [`L2_TAG_BITS-1:0]  m_tag   [`L2_SETS][`L2_WAYS];
    bit                       m_valid [`L2_SETS][`L2_WAYS];
    bit                       m_dirty [`L2_SETS][`L2_WAYS];
    int                       m_order [`L2_SETS][`L2_WAYS];   // Head is the victim

    // Memory transfers still expected, in order
    bit            q_wr [$];
    l2_pkg::word_t q_addr [$];
    l2_pkg::word_t q_data [$];

    l2_cache_top uut (
        .CLK        (CLK),
        .nRST       (nRST),
        .proc_ren   (proc_ren),
        .proc_wen   (proc_wen),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_rdata (proc_rdata),
        .proc_busy  (proc_busy),
        .mem_ren    (mem_ren),
        .mem_wen    (mem_wen),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_busy   (mem_busy)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    initial begin
        #((NUM_ACC * ACC_CYCLES + 2 * RESET_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired before all accesses finished");
        $display("STATUS: FAIL");
        $fatal(1, "watchdog timeout");
    end

    ////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////
    task automatic report_error(input string msg);
        error_count++;
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input l2_pkg::word_t got,
                              input l2_pkg::word_t exp);
        if (got !== exp) begin
            report_error($sformatf("[FAIL] t=%0t %s got=%h exp=%h", $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input l2_pkg::l2_addr_t got,
                              input l2_pkg::l2_addr_t exp);
        if (got !== exp) begin
            report_error($sformatf("[FAIL] t=%0t %s got=%h exp=%h", $time, name, got, exp));
        end
    endtask

    // Protocol checker bound into the DUT
    always @(negedge CLK) begin
        if (uut.u_assert.fail_count != 0) begin
            report_error("A bus protocol assertion failed");
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Model helpers
    ////////////////////////////////////////////////////////////////////////
    function automatic l2_pkg::word_t fill_value(input l2_pkg::word_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'h3C5A_A5C3;
    endfunction

    function automatic l2_pkg::word_t model_read(input l2_pkg::word_t addr);
        return exp_words.exists(addr) ? exp_words[addr] : fill_value(addr);
    endfunction

    function automatic l2_pkg::word_t mem_read(input l2_pkg::word_t addr);
        return mem_words.exists(addr) ? mem_words[addr] : fill_value(addr);
    endfunction

    function automatic l2_pkg::l2_addr_t make_addr(input int tag_n, input int set_n,
                                                   input int word_n);
        l2_pkg::word_t w;
        w = (l2_pkg::word_t'(tag_n) << (`L2_SET_BITS + `L2_WORD_BITS + 2))
          | (l2_pkg::word_t'(set_n) << (`L2_WORD_BITS + 2))
          | (l2_pkg::word_t'(word_n) << 2);
        return l2_pkg::l2_addr_t'(w);
    endfunction

    task automatic touch_model(input int s, input int w);
        int pos;
        pos = 0;
        for (int i = 0; i < `L2_WAYS; i++) begin
            if (m_order[s][i] == w) pos = i;
        end
        for (int i = pos; i < `L2_WAYS - 1; i++) begin
            m_order[s][i] = m_order[s][i+1];    // Close the gap
        end
        m_order[s][`L2_WAYS-1] = w;             // Most recently used
    endtask

    task automatic push_transfer(input bit wr, input l2_pkg::word_t addr,
                                 input l2_pkg::word_t data);
        q_wr.push_back(wr);
        q_addr.push_back(addr);
        q_data.push_back(data);
    endtask

    ////////////////////////////////////////////////////////////////////////
    // One processor access, started and ended on a falling edge
    ////////////////////////////////////////////////////////////////////////
    task automatic do_access(input bit is_write, input l2_pkg::l2_addr_t a);
        l2_pkg::word_t    addr;
        l2_pkg::word_t    wdata;
        l2_pkg::word_t    rdata;
        l2_pkg::word_t    exp_rd;
        l2_pkg::l2_addr_t line_a;
        int               s;
        int               way;
        int               cycles;
        bit               hit_exp;
        bit               done;
        addr    = a;
        wdata   = $random(seed);
        exp_rd  = model_read(addr);
        s       = int'(a.set);
        way     = -1;
        hit_exp = 1'b0;
        if (addr >= `L2_NONCACHE_BASE) begin
            push_transfer(is_write, addr, wdata);       // Single pass-through
        end else begin
            for (int w = 0; w < `L2_WAYS; w++) begin
                if (m_valid[s][w] && (m_tag[s][w] == a.tag)) way = w;
            end
            hit_exp = (way >= 0);
            if (!hit_exp) begin
                way    = m_order[s][0];
                line_a = a;
                line_a.byte_off = '0;
                if (m_valid[s][way] && m_dirty[s][way]) begin
                    line_a.tag = m_tag[s][way];         // Victim line first
                    for (int k = 0; k < `L2_BLOCK; k++) begin
                        line_a.word = k[`L2_WORD_BITS-1:0];
                        push_transfer(1'b1, line_a, model_read(line_a));
                    end
                end
                line_a.tag = a.tag;
                for (int k = 0; k < `L2_BLOCK; k++) begin
                    line_a.word = k[`L2_WORD_BITS-1:0];
                    push_transfer(1'b0, line_a, '0);
                end
                m_tag[s][way]   = a.tag;
                m_valid[s][way] = 1'b1;
                m_dirty[s][way] = 1'b0;
            end
            touch_model(s, way);
            if (is_write) m_dirty[s][way] = 1'b1;
        end

        proc_addr  = addr;
        proc_wdata = wdata;
        proc_ren   = !is_write;
        proc_wen   = is_write;
        cycles     = 0;
        done       = 1'b0;
        while (!done) begin
            @(posedge CLK);
            cycles++;
            if (!proc_busy) begin
                done  = 1'b1;
                rdata = proc_rdata;
            end else if (cycles > ACC_CYCLES) begin
                report_error($sformatf("Access to %h did not complete in time", addr));
            end
        end
        @(negedge CLK);
        proc_ren = 1'b0;
        proc_wen = 1'b0;

        if (!is_write) check_word("proc_rdata", rdata, exp_rd);
        if (hit_exp && (cycles != 1)) begin
            report_error($sformatf("Hit on %h took %0d cycles instead of one", addr, cycles));
        end
        if (q_addr.size() != 0) begin
            report_error($sformatf("Access to %h ended with memory transfers missing", addr));
        end
        if (is_write) exp_words[addr] = wdata;
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Memory responder
    ////////////////////////////////////////////////////////////////////////
    always @(negedge CLK) begin
        mem_busy  = (wait_left != 0);
        mem_rdata = mem_read(mem_addr);
    end

    always @(posedge CLK) begin
        if (nRST && (mem_ren || mem_wen)) begin
            if (mem_busy) begin
                if (wait_left != 0) wait_left--;
            end else begin
                if (q_addr.size() == 0) begin
                    report_error($sformatf("Memory transfer to %h with none expected", mem_addr));
                end else begin
                    if (q_wr[0] != mem_wen) begin
                        report_error($sformatf("Wrong memory transfer kind at %h", mem_addr));
                    end
                    check_addr("mem_addr", mem_addr, q_addr[0]);
                    if (mem_wen) begin
                        check_word("mem_wdata", mem_wdata, q_data[0]);
                        mem_words[mem_addr] = mem_wdata;
                    end
                    void'(q_wr.pop_front());
                    void'(q_addr.pop_front());
                    void'(q_data.pop_front());
                end
                wait_left = {$random(seed)} % 4;   // Stall for the next word
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////
    initial begin
        l2_pkg::l2_addr_t a;
        bit               is_write;
        int               tag_n;
        int               set_n;
        int               word_n;
        proc_ren   = 1'b0;
        proc_wen   = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        nRST       = 1'b0;
        for (int s = 0; s < `L2_SETS; s++) begin
            for (int w = 0; w < `L2_WAYS; w++) begin
                m_order[s][w] = w;              // Way 0 is the first victim
            end
        end
        repeat (RESET_CYCLES) @(negedge CLK);
        nRST = 1'b1;
        @(negedge CLK);
        if (proc_busy !== 1'b1) report_error("proc_busy is low after reset with no request");

        // Five dirty lines in one set, then the evicted one again
        for (int t = 0; t < 5; t++) begin
            do_access(1'b1, make_addr(t, 2, 1));
        end
        do_access(1'b0, make_addr(0, 2, 1));

        for (int n = 0; n < NUM_ACC - DIRECTED_ACC; n++) begin
            is_write = ({$random(seed)} % 2) == 1;
            if (({$random(seed)} % 8) == 0) begin
                word_n = {$random(seed)} % 4;
                a = l2_pkg::l2_addr_t'(`L2_NONCACHE_BASE + l2_pkg::word_t'(word_n * 'h104));
            end else begin
                tag_n  = {$random(seed)} % 6;   // Six lines per set force evictions
                set_n  = (({$random(seed)} % 2) == 0) ? 1 : 6;
                word_n = {$random(seed)} % 4;
                a = make_addr(tag_n, set_n, word_n);
            end
            do_access(is_write, a);
        end

        if ((error_count == 0) && (uut.u_assert.fail_count == 0)) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("STATUS: FAIL");
            $fatal(1, "errors found");
        end
    end

endmodule

// ==== tb/l2_cache_assert.sv ====
// L2 cache bus protocol assertions
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2_cache_assert (
    input logic                  CLK,
    input logic                  nRST,
    input logic                  proc_ren,
    input logic                  proc_wen,
    input logic                  mem_ren,
    input logic                  mem_wen,
    input logic [`L2_WORD_W-1:0] mem_addr,
    input logic [`L2_WORD_W-1:0] mem_wdata,
    input logic                  mem_busy
);

    int unsigned fail_count = 0;                // Failed assertions so far

    // One direction per transfer on each bus
    one_cmd: assert property (@(posedge CLK) disable iff (!nRST)
        !(proc_ren && proc_wen) && !(mem_ren && mem_wen))
        else begin
            fail_count++;
            $error("ren and wen high together");
        end

    // Request held while the memory stalls
    hold_req: assert property (@(posedge CLK) disable iff (!nRST)
        (mem_ren || mem_wen) && mem_busy |=>
            $stable(mem_ren) && $stable(mem_wen) && $stable(mem_addr) && $stable(mem_wdata))
        else begin
            fail_count++;
            $error("memory request changed while mem_busy was high");
        end

    quiet_reset: assert property (@(posedge CLK) !nRST |-> !mem_ren && !mem_wen)
        else begin
            fail_count++;
            $error("memory request during reset");
        end

endmodule

bind l2_cache_top l2_cache_assert u_assert (
    .CLK       (CLK),
    .nRST      (nRST),
    .proc_ren  (proc_ren),
    .proc_wen  (proc_wen),
    .mem_ren   (mem_ren),
    .mem_wen   (mem_wen),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_busy  (mem_busy)
);

// ==== verilog/l2_cache_top.sv ====
// L2 cache top level
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2_cache_top (
    input  logic                  CLK,
    input  logic                  nRST,
    // Processor side
    input  logic                  proc_ren,
    input  logic                  proc_wen,
    input  logic [`L2_WORD_W-1:0] proc_addr,
    input  logic [`L2_WORD_W-1:0] proc_wdata,
    output logic [`L2_WORD_W-1:0] proc_rdata,
    output logic                  proc_busy,
    // Memory side
    output logic                  mem_ren,
    output logic                  mem_wen,
    output logic [`L2_WORD_W-1:0] mem_addr,
    output logic [`L2_WORD_W-1:0] mem_wdata,
    input  logic [`L2_WORD_W-1:0] mem_rdata,
    input  logic                  mem_busy
);

    l2_array_if arr_bus ();
    l2_repl_if  repl_bus ();

    l2_controller u_ctrl (
        .CLK        (CLK),
        .nRST       (nRST),
        .proc_ren   (proc_ren),
        .proc_wen   (proc_wen),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_rdata (proc_rdata),
        .proc_busy  (proc_busy),
        .mem_ren    (mem_ren),
        .mem_wen    (mem_wen),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_busy   (mem_busy),
        .arr        (arr_bus.ctrl),
        .repl       (repl_bus.ctrl)
    );

    l2_line_store u_store (
        .CLK    (CLK),
        .nRST   (nRST),
        .arr    (arr_bus.store),
        .victim (repl_bus.victim)           // LRU head of the looked-up set
    );

    l2_lru u_lru (
        .CLK  (CLK),
        .nRST (nRST),
        .repl (repl_bus.lru)
    );

endmodule

// ==== verilog/l2_controller.sv ====
// L2 cache controller
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2_controller (
    input  logic           CLK,
    input  logic           nRST,
    // Processor side
    input  logic           proc_ren,
    input  logic           proc_wen,
    input  l2_pkg::word_t  proc_addr,
    input  l2_pkg::word_t  proc_wdata,
    output l2_pkg::word_t  proc_rdata,
    output logic           proc_busy,
    // Memory side
    output logic           mem_ren,
    output logic           mem_wen,
    output l2_pkg::word_t  mem_addr,
    output l2_pkg::word_t  mem_wdata,
    input  l2_pkg::word_t  mem_rdata,
    input  logic           mem_busy,
    l2_array_if.ctrl       arr,
    l2_repl_if.ctrl        repl
);

    l2_pkg::ctrl_state_t       state;
    l2_pkg::ctrl_state_t       next_state;
    logic [`L2_WORD_BITS-1:0]  word_cnt;
    l2_pkg::l2_addr_t          cur_addr;
    l2_pkg::l2_addr_t          line_addr;       // Missed line, word cleared
    l2_pkg::l2_addr_t          look_addr;
    l2_pkg::way_t              vict_way;
    logic                      req;
    logic                      uncached;
    logic                      start_miss;
    logic                      word_step;
    logic                      last_word;

    assign cur_addr   = proc_addr;
    assign req        = proc_ren || proc_wen;
    assign uncached   = (proc_addr >= `L2_NONCACHE_BASE);
    assign start_miss = (state == l2_pkg::IDLE) && req && !uncached && !arr.hit;
    assign word_step  = ((state == l2_pkg::WRITEBACK) || (state == l2_pkg::FETCH)) && !mem_busy;
    assign last_word  = (word_cnt == (`L2_WORD_BITS)'(`L2_BLOCK - 1));

    // Live address while idle, latched line during a miss
    assign look_addr = (state == l2_pkg::IDLE) ? cur_addr : line_addr;

    assign arr.lookup_addr = look_addr;
    assign arr.fill_way    = vict_way;
    assign arr.fill_word   = word_cnt;
    assign arr.fill_data   = mem_rdata;
    assign arr.wb_word     = word_cnt;
    assign arr.hit_wdata   = proc_wdata;
    assign repl.set        = look_addr.set;

    ////////////////////////////////////////////////////////////////////////
    // State and word counter
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state    <= l2_pkg::IDLE;
            word_cnt <= '0;
        end else begin
            state <= next_state;
            if (word_step) begin
                word_cnt <= last_word ? '0 : word_cnt + 1'b1;
            end
        end
    end

    // Miss context
    always_ff @(posedge CLK) begin
        if (start_miss) begin
            line_addr <= '{tag: cur_addr.tag, set: cur_addr.set, word: '0, byte_off: '0};
            vict_way  <= repl.victim;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Next state and bus outputs
    ////////////////////////////////////////////////////////////////////////
    always_comb begin
        next_state     = state;
        proc_busy      = 1'b1;
        proc_rdata     = arr.hit_data;
        mem_ren        = 1'b0;
        mem_wen        = 1'b0;
        mem_addr       = '0;
        mem_wdata      = '0;
        arr.fill_we    = 1'b0;
        arr.hit_we     = 1'b0;
        arr.tag_we     = 1'b0;
        arr.mark_clean = 1'b0;
        repl.touch     = 1'b0;
        repl.touch_way = arr.hit_way;

        case (state)
            l2_pkg::IDLE: begin
                if (req) begin
                    if (uncached) begin
                        next_state = l2_pkg::BYPASS;
                    end else if (arr.hit) begin
                        proc_busy  = 1'b0;          // Hit done this cycle
                        arr.hit_we = proc_wen;
                        repl.touch = 1'b1;
                    end else if (arr.victim_dirty) begin
                        next_state = l2_pkg::WRITEBACK;
                    end else begin
                        next_state = l2_pkg::FETCH;
                    end
                end
            end
            l2_pkg::WRITEBACK: begin
                mem_wen   = 1'b1;
                mem_addr  = {arr.victim_tag, line_addr.set, word_cnt, 2'b00};
                mem_wdata = arr.wb_data;
                if (!mem_busy && last_word) begin
                    arr.mark_clean = 1'b1;
                    next_state     = l2_pkg::FETCH;
                end
            end
            l2_pkg::FETCH: begin
                mem_ren     = 1'b1;
                mem_addr    = {line_addr.tag, line_addr.set, word_cnt, 2'b00};
                arr.fill_we = !mem_busy;
                if (!mem_busy && last_word) begin
                    arr.tag_we     = 1'b1;
                    repl.touch     = 1'b1;
                    repl.touch_way = vict_way;
                    next_state     = l2_pkg::IDLE;  // Access then hits
                end
            end
            l2_pkg::BYPASS: begin
                mem_ren    = proc_ren;
                mem_wen    = proc_wen;
                mem_addr   = proc_addr;
                mem_wdata  = proc_wdata;
                proc_rdata = mem_rdata;
                proc_busy  = mem_busy;
                if (!mem_busy) begin
                    next_state = l2_pkg::IDLE;
                end
            end
            default: begin
                next_state = l2_pkg::IDLE;
            end
        endcase
    end

endmodule

// ==== verilog/l2_lru.sv ====
// L2 true-LRU order lists
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2_lru (
    input  logic     CLK,
    input  logic     nRST,
    l2_repl_if.lru   repl
);

    // Index 0 is the victim, the last index the most recently used
    l2_pkg::way_t [`L2_WAYS-1:0] order [`L2_SETS];

    l2_pkg::way_t [`L2_WAYS-1:0] cur_list;
    l2_pkg::way_t [`L2_WAYS-1:0] next_list;
    l2_pkg::way_t                pos;       // Slot of touch_way in cur_list

    assign cur_list    = order[repl.set];
    assign repl.victim = cur_list[0];

    ////////////////////////////////////////////////////////////////////////
    // Move touched way to the tail
    ////////////////////////////////////////////////////////////////////////
    always_comb begin
        pos = '0;
        for (int i = 0; i < `L2_WAYS; i++) begin
            if (cur_list[i] == repl.touch_way) begin
                pos = l2_pkg::way_t'(i);
            end
        end
        for (int i = 0; i < `L2_WAYS - 1; i++) begin
            next_list[i] = (i < pos) ? cur_list[i] : cur_list[i+1];  // Close the gap
        end
        next_list[`L2_WAYS-1] = repl.touch_way;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < `L2_SETS; s++) begin
                for (int w = 0; w < `L2_WAYS; w++) begin
                    order[s][w] <= l2_pkg::way_t'(w);   // Way 0 first victim
                end
            end
        end else if (repl.touch) begin
            order[repl.set] <= next_list;
        end
    end

endmodule

// ==== verilog/l2_line_store.sv ====
// L2 line storage and tag compare
`timescale 1ns/1ps
`include "l2_defines.svh"

module l2_line_store (
    input  logic         CLK,
    input  logic         nRST,
    l2_array_if.store    arr,
    input  l2_pkg::way_t victim
);

    logic                     valid [`L2_SETS][`L2_WAYS];
    logic                     dirty [`L2_SETS][`L2_WAYS];
    logic [`L2_TAG_BITS-1:0]  tag   [`L2_SETS][`L2_WAYS];
    l2_pkg::word_t            data  [`L2_SETS][`L2_WAYS][`L2_BLOCK];

    logic [`L2_SET_BITS-1:0]  set_idx;

    assign set_idx = arr.lookup_addr.set;

    ////////////////////////////////////////////////////////////////////////
    // Parallel tag compare
    ////////////////////////////////////////////////////////////////////////
    always_comb begin
        arr.hit     = 1'b0;
        arr.hit_way = '0;
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (valid[set_idx][w] && (tag[set_idx][w] == arr.lookup_addr.tag)) begin
                arr.hit     = 1'b1;
                arr.hit_way = l2_pkg::way_t'(w);
            end
        end
    end

    assign arr.hit_data = data[set_idx][arr.hit_way][arr.lookup_addr.word];

    // Victim line as named by the LRU
    assign arr.victim_dirty = valid[set_idx][victim] && dirty[set_idx][victim];
    assign arr.victim_tag   = tag[set_idx][victim];
    assign arr.wb_data      = data[set_idx][victim][arr.wb_word];

    ////////////////////////////////////////////////////////////////////////
    // State bits
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < `L2_SETS; s++) begin
                for (int w = 0; w < `L2_WAYS; w++) begin
                    valid[s][w] <= 1'b0;
                    dirty[s][w] <= 1'b0;
                end
            end
        end else begin
            if (arr.mark_clean) begin
                dirty[set_idx][arr.fill_way] <= 1'b0;   // Write-back done
            end
            if (arr.tag_we) begin
                valid[set_idx][arr.fill_way] <= 1'b1;
                dirty[set_idx][arr.fill_way] <= 1'b0;
            end
            if (arr.hit_we) begin
                dirty[set_idx][arr.hit_way] <= 1'b1;
            end
        end
    end

    // Tags and line data
    always_ff @(posedge CLK) begin
        if (arr.tag_we) begin
            tag[set_idx][arr.fill_way] <= arr.lookup_addr.tag;
        end
        if (arr.fill_we) begin
            data[set_idx][arr.fill_way][arr.fill_word] <= arr.fill_data;
        end
        if (arr.hit_we) begin
            data[set_idx][arr.hit_way][arr.lookup_addr.word] <= arr.hit_wdata;
        end
    end

endmodule

// ==== verilog/l2_if.sv ====
// L2 cache internal interfaces
`timescale 1ns/1ps
`include "l2_defines.svh"

////////////////////////////////////////////////////////////////////////////
// Controller to line store
////////////////////////////////////////////////////////////////////////////
interface l2_array_if;
    l2_pkg::l2_addr_t          lookup_addr;     // Selects set, tag and word
    logic                      fill_we;
    l2_pkg::way_t              fill_way;        // Victim way being refilled
    logic [`L2_WORD_BITS-1:0]  fill_word;
    l2_pkg::word_t             fill_data;
    logic                      hit_we;
    l2_pkg::word_t             hit_wdata;
    logic                      tag_we;          // Install tag and set valid
    logic                      mark_clean;
    logic [`L2_WORD_BITS-1:0]  wb_word;
    logic                      hit;
    l2_pkg::way_t              hit_way;
    l2_pkg::word_t             hit_data;
    logic                      victim_dirty;
    logic [`L2_TAG_BITS-1:0]   victim_tag;
    l2_pkg::word_t             wb_data;

    modport ctrl (
        output lookup_addr, fill_we, fill_way, fill_word, fill_data,
        output hit_we, hit_wdata, tag_we, mark_clean, wb_word,
        input  hit, hit_way, hit_data, victim_dirty, victim_tag, wb_data
    );

    modport store (
        input  lookup_addr, fill_we, fill_way, fill_word, fill_data,
        input  hit_we, hit_wdata, tag_we, mark_clean, wb_word,
        output hit, hit_way, hit_data, victim_dirty, victim_tag, wb_data
    );
endinterface

////////////////////////////////////////////////////////////////////////////
// Controller to LRU
////////////////////////////////////////////////////////////////////////////
interface l2_repl_if;
    logic [`L2_SET_BITS-1:0] set;
    logic                    touch;             // Move touch_way to MRU
    l2_pkg::way_t            touch_way;
    l2_pkg::way_t            victim;            // LRU head of the set

    modport ctrl (output set, touch, touch_way, input victim);
    modport lru  (input set, touch, touch_way, output victim);
endinterface

// ==== verilog/l2_pkg.sv ====
// L2 cache shared types
`include "l2_defines.svh"

package l2_pkg;

    // Data word on both buses
    typedef logic [`L2_WORD_W-1:0] word_t;

    // Way index within a set
    typedef logic [$clog2(`L2_WAYS)-1:0] way_t;

    // Controller states
    typedef enum logic [1:0] {
        IDLE,                               // Hits served here
        WRITEBACK,                          // Dirty victim to memory
        FETCH,                              // New line from memory
        BYPASS                              // Uncached single transfer
    } ctrl_state_t;

    // Decoded byte address
    typedef struct packed {
        logic [`L2_TAG_BITS-1:0]  tag;
        logic [`L2_SET_BITS-1:0]  set;
        logic [`L2_WORD_BITS-1:0] word;
        logic [1:0]               byte_off;
    } l2_addr_t;

endpackage

// ==== verilog/l2_defines.svh ====
// L2 cache geometry macros
`ifndef L2_DEFINES_SVH
`define L2_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Geometry
////////////////////////////////////////////////////////////////////////////
`define L2_WORD_W   32                      // Data and address width
`define L2_SETS     8
`define L2_WAYS     4
`define L2_BLOCK    4                       // Words per line

////////////////////////////////////////////////////////////////////////////
// Address field widths
////////////////////////////////////////////////////////////////////////////
`define L2_SET_BITS  $clog2(`L2_SETS)
`define L2_WORD_BITS $clog2(`L2_BLOCK)
`define L2_TAG_BITS  (`L2_WORD_W - `L2_SET_BITS - `L2_WORD_BITS - 2)

`define L2_NONCACHE_BASE 32'h8000_0000      // First uncached address

`endif
